//--- logic/dbg_pkg.sv
package dbg_pkg;

  ////////////////////////////////////////////////////////////
  // Bus geometry
  ////////////////////////////////////////////////////////////

  // Wishbone data word
  parameter int unsigned DataWidth = 32;

  // Byte address seen by the bus
  parameter int unsigned AddrWidth = 32;

  // One select per byte lane
  parameter int unsigned SelWidth = DataWidth / 8;

  ////////////////////////////////////////////////////////////
  // Serial protocol codes
  ////////////////////////////////////////////////////////////

  // Command bytes from the host and response bytes back to it
  typedef enum logic [7:0] {
    DbgEot      = 8'h04,
    DbgAck      = 8'h06,
    DbgCmdRead  = 8'h11,
    DbgCmdWrite = 8'h12
  } dbg_byte_e;

endpackage

//--- logic/uart_rx.sv
module uart_rx #(
  parameter int unsigned ClksPerBit = 16
) (
  input  logic       jtag_tck,
  input  logic       rst_n_i,
  input  logic       rx_i,
  output logic [7:0] data_o,
  output logic       valid_o
);

  localparam int unsigned CntWidth = $clog2(ClksPerBit + 1);
  localparam logic [CntWidth-1:0] CntHalf = CntWidth'((ClksPerBit - 1) / 2);
  localparam logic [CntWidth-1:0] CntFull = CntWidth'(ClksPerBit - 1);

  typedef enum logic [1:0] {
    RxIdle,
    RxStart,
    RxData,
    RxStop
  } rx_state_e;

  rx_state_e           state_q;
  logic [2:0]          line_q;
  logic [CntWidth-1:0] cnt_q;
  logic [2:0]          bit_q;
  logic [7:0]          shift_q;
  logic                rx_s;
  logic                fall;

  // Two flops against metastability, the third only for edge detection
  assign rx_s = line_q[1];
  assign fall = line_q[2] & ~line_q[1];

  always_ff @(posedge jtag_tck) begin
    if (!rst_n_i) begin
      line_q  <= 3'b111;
      state_q <= RxIdle;
      cnt_q   <= '0;
      bit_q   <= '0;
      valid_o <= 1'b0;
    end else begin
      line_q  <= {line_q[1:0], rx_i};
      valid_o <= 1'b0;
      case (state_q)
        RxIdle: begin
          if (fall) begin
            state_q <= RxStart;
            cnt_q   <= '0;
          end
        end
        // Wait half a bit, then confirm the start bit is still low
        RxStart: begin
          if (cnt_q == CntHalf) begin
            cnt_q   <= '0;
            bit_q   <= '0;
            state_q <= rx_s ? RxIdle : RxData;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        RxData: begin
          if (cnt_q == CntFull) begin
            cnt_q   <= '0;
            bit_q   <= bit_q + 1'b1;
            if (bit_q == 3'd7) begin
              state_q <= RxStop;
            end
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        // Frame only counts with a high stop bit
        RxStop: begin
          if (cnt_q == CntFull) begin
            state_q <= RxIdle;
            valid_o <= rx_s;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        default: state_q <= RxIdle;
      endcase
    end
  end

  // LSB arrives first
  always_ff @(posedge jtag_tck) begin
    if (state_q == RxData && cnt_q == CntFull) begin
      shift_q <= {rx_s, shift_q[7:1]};
    end
  end

  assign data_o = shift_q;

endmodule

//--- logic/uart_tx.sv
module uart_tx #(
  parameter int unsigned ClksPerBit = 16
) (
  input  logic       jtag_tck,
  input  logic       rst_n_i,
  input  logic [7:0] data_i,
  input  logic       start_i,
  output logic       busy_o,
  output logic       tx_o
);

  localparam int unsigned CntWidth = $clog2(ClksPerBit + 1);
  localparam logic [CntWidth-1:0] CntFull = CntWidth'(ClksPerBit - 1);

  // Stop bit, data LSB first, start bit at position 0
  logic [9:0]          shift_q;
  logic [3:0]          bit_q;
  logic [CntWidth-1:0] cnt_q;

  always_ff @(posedge jtag_tck) begin
    if (!rst_n_i) begin
      shift_q <= '1;
      bit_q   <= '0;
      cnt_q   <= '0;
      busy_o  <= 1'b0;
    end else if (!busy_o) begin
      if (start_i) begin
        shift_q <= {1'b1, data_i, 1'b0};
        bit_q   <= '0;
        cnt_q   <= '0;
        busy_o  <= 1'b1;
      end
    end else if (cnt_q == CntFull) begin
      cnt_q <= '0;
      // Ones shift in behind the frame so the line ends up idle high
      shift_q <= {1'b1, shift_q[9:1]};
      if (bit_q == 4'd9) begin
        busy_o <= 1'b0;
      end else begin
        bit_q <= bit_q + 1'b1;
      end
    end else begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  assign tx_o = shift_q[0];

endmodule

//--- logic/dbg_cmd_engine.sv
module dbg_cmd_engine (
  input  logic                           jtag_tck,
  input  logic                           rst_n_i,
  // Byte stream from the receiver
  input  logic [7:0]                     rx_data_i,
  input  logic                           rx_valid_i,
  // Byte stream to the transmitter
  output logic [7:0]                     tx_data_o,
  output logic                           tx_start_o,
  input  logic                           tx_busy_i,
  // Wishbone classic master
  output logic                           wb_cyc_o,
  output logic                           wb_stb_o,
  output logic                           wb_we_o,
  output logic [dbg_pkg::AddrWidth-1:0]  wb_adr_o,
  output logic [dbg_pkg::SelWidth-1:0]   wb_sel_o,
  output logic [dbg_pkg::DataWidth-1:0]  wb_dat_o,
  input  logic [dbg_pkg::DataWidth-1:0]  wb_dat_i,
  input  logic                           wb_ack_i
);

  localparam int unsigned HdrBytes = dbg_pkg::AddrWidth / 8;
  localparam int unsigned HdrCntW  = $clog2(HdrBytes);
  localparam int unsigned LaneBits = $clog2(dbg_pkg::SelWidth);

  typedef enum logic [2:0] {
    StIdle,
    StAddr,
    StLen,
    StSendAck,
    StLoop,
    StBusWait,
    StSendData,
    StSendEot
  } eng_state_e;

  eng_state_e                    state_q;
  dbg_pkg::dbg_byte_e            cmd_q;
  logic [HdrCntW-1:0]            hdr_cnt_q;
  logic                          bus_q;
  logic                          we_q;
  logic [dbg_pkg::AddrWidth-1:0] adr_q;
  logic [dbg_pkg::AddrWidth-1:0] len_q;
  logic [7:0]                    wdata_q;
  logic [7:0]                    rd_byte_q;
  logic [LaneBits-1:0]           lane;
  logic                          hdr_last;
  logic                          sending;

  ////////////////////////////////////////////////////////////
  // Response bytes
  ////////////////////////////////////////////////////////////

  assign sending = (state_q == StSendAck) || (state_q == StSendData) ||
                   (state_q == StSendEot);

  // Only fire when the transmitter is free
  assign tx_start_o = sending & ~tx_busy_i;

  always_comb begin
    case (state_q)
      StSendAck:  tx_data_o = dbg_pkg::DbgAck;
      StSendEot:  tx_data_o = dbg_pkg::DbgEot;
      default:    tx_data_o = rd_byte_q;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Bus side
  ////////////////////////////////////////////////////////////

  assign lane     = adr_q[LaneBits-1:0];
  assign hdr_last = (hdr_cnt_q == HdrCntW'(HdrBytes - 1));

  assign wb_cyc_o = bus_q;
  assign wb_stb_o = bus_q;
  assign wb_we_o  = we_q;
  assign wb_adr_o = adr_q;
  assign wb_sel_o = {{(dbg_pkg::SelWidth - 1){1'b0}}, 1'b1} << lane;
  // Same byte on every lane, sel picks the one that lands
  assign wb_dat_o = {dbg_pkg::SelWidth{wdata_q}};

  ////////////////////////////////////////////////////////////
  // Control FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge jtag_tck) begin
    if (!rst_n_i) begin
      state_q   <= StIdle;
      cmd_q     <= dbg_pkg::DbgAck;
      hdr_cnt_q <= '0;
      bus_q     <= 1'b0;
      we_q      <= 1'b0;
    end else begin
      case (state_q)
        StIdle: begin
          if (rx_valid_i) begin
            case (rx_data_i)
              dbg_pkg::DbgAck: begin
                cmd_q   <= dbg_pkg::DbgAck;
                state_q <= StSendAck;
              end
              dbg_pkg::DbgCmdRead, dbg_pkg::DbgCmdWrite: begin
                cmd_q     <= dbg_pkg::dbg_byte_e'(rx_data_i);
                hdr_cnt_q <= '0;
                state_q   <= StAddr;
              end
              // Unknown codes are dropped silently
              default: state_q <= StIdle;
            endcase
          end
        end
        StAddr: begin
          if (rx_valid_i) begin
            hdr_cnt_q <= hdr_cnt_q + 1'b1;
            if (hdr_last) begin
              state_q <= StLen;
            end
          end
        end
        StLen: begin
          if (rx_valid_i) begin
            hdr_cnt_q <= hdr_cnt_q + 1'b1;
            if (hdr_last) begin
              state_q <= StSendAck;
            end
          end
        end
        // Challenge ends here, commands go on to the data phase
        StSendAck: begin
          if (tx_start_o) begin
            state_q <= (cmd_q == dbg_pkg::DbgAck) ? StIdle : StLoop;
          end
        end
        StLoop: begin
          if (len_q == '0) begin
            state_q <= StSendEot;
          end else if (cmd_q == dbg_pkg::DbgCmdRead) begin
            bus_q   <= 1'b1;
            we_q    <= 1'b0;
            state_q <= StBusWait;
          end else if (rx_valid_i) begin
            bus_q   <= 1'b1;
            we_q    <= 1'b1;
            state_q <= StBusWait;
          end
        end
        StBusWait: begin
          if (wb_ack_i) begin
            bus_q   <= 1'b0;
            we_q    <= 1'b0;
            state_q <= we_q ? StLoop : StSendData;
          end
        end
        StSendData: begin
          if (tx_start_o) begin
            state_q <= StLoop;
          end
        end
        StSendEot: begin
          if (tx_start_o) begin
            state_q <= StIdle;
          end
        end
        default: state_q <= StIdle;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Header and data registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge jtag_tck) begin
    // Address and length arrive LSB first
    if (state_q == StAddr && rx_valid_i) begin
      adr_q <= {rx_data_i, adr_q[dbg_pkg::AddrWidth-1:8]};
    end else if (state_q == StBusWait && wb_ack_i) begin
      adr_q <= adr_q + 1'b1;
    end

    if (state_q == StLen && rx_valid_i) begin
      len_q <= {rx_data_i, len_q[dbg_pkg::AddrWidth-1:8]};
    end else if (state_q == StBusWait && wb_ack_i) begin
      len_q <= len_q - 1'b1;
    end

    if (state_q == StLoop && rx_valid_i) begin
      wdata_q <= rx_data_i;
    end

    // Pick the addressed lane out of the returned word
    if (state_q == StBusWait && wb_ack_i && !we_q) begin
      rd_byte_q <= wb_dat_i[{lane, 3'b000} +: 8];
    end
  end

endmodule

//--- logic/wb_ram.sv
module wb_ram #(
  parameter int unsigned MemWords = 256
) (
  input  logic                          jtag_tck,
  input  logic                          rst_n_i,
  input  logic                          wb_cyc_i,
  input  logic                          wb_stb_i,
  input  logic                          wb_we_i,
  input  logic [dbg_pkg::AddrWidth-1:0] wb_adr_i,
  input  logic [dbg_pkg::SelWidth-1:0]  wb_sel_i,
  input  logic [dbg_pkg::DataWidth-1:0] wb_dat_i,
  output logic [dbg_pkg::DataWidth-1:0] wb_dat_o,
  output logic                          wb_ack_o
);

  localparam int unsigned OffBits = $clog2(dbg_pkg::SelWidth);
  localparam int unsigned IdxBits = $clog2(MemWords);

  logic [dbg_pkg::DataWidth-1:0] mem_q [MemWords];
  logic [IdxBits-1:0]            idx;
  logic                          req;

  // Upper address bits are ignored so accesses wrap around the array
  assign idx = wb_adr_i[OffBits +: IdxBits];

  // Masked while ack is up, which keeps ack to single cycles
  assign req = wb_cyc_i & wb_stb_i & ~wb_ack_o;

  always_ff @(posedge jtag_tck) begin
    if (!rst_n_i) begin
      wb_ack_o <= 1'b0;
    end else begin
      wb_ack_o <= req;
    end
  end

  always_ff @(posedge jtag_tck) begin
    if (req) begin
      wb_dat_o <= mem_q[idx];
      if (wb_we_i) begin
        for (int i = 0; i < dbg_pkg::SelWidth; i++) begin
          if (wb_sel_i[i]) begin
            mem_q[idx][8*i +: 8] <= wb_dat_i[8*i +: 8];
          end
        end
      end
    end
  end

endmodule

//--- logic/uart_dbg_top.sv
module uart_dbg_top #(
  parameter int unsigned ClksPerBit = 16,
  parameter int unsigned MemWords   = 256
) (
  input  logic jtag_tck,
  input  logic rst_n_i,
  input  logic uart_rx_i,
  output logic uart_tx_o
);

  logic [7:0]                    rx_data;
  logic                          rx_valid;
  logic [7:0]                    tx_data;
  logic                          tx_start;
  logic                          tx_busy;
  logic                          wb_cyc;
  logic                          wb_stb;
  logic                          wb_we;
  logic [dbg_pkg::AddrWidth-1:0] wb_adr;
  logic [dbg_pkg::SelWidth-1:0]  wb_sel;
  logic [dbg_pkg::DataWidth-1:0] wb_wdata;
  logic [dbg_pkg::DataWidth-1:0] wb_rdata;
  logic                          wb_ack;

  ////////////////////////////////////////////////////////////
  // Serial line
  ////////////////////////////////////////////////////////////

  uart_rx #(
    .ClksPerBit (ClksPerBit)
  ) u_uart_rx (
    .jtag_tck (jtag_tck),
    .rst_n_i  (rst_n_i),
    .rx_i     (uart_rx_i),
    .data_o   (rx_data),
    .valid_o  (rx_valid)
  );

  uart_tx #(
    .ClksPerBit (ClksPerBit)
  ) u_uart_tx (
    .jtag_tck (jtag_tck),
    .rst_n_i  (rst_n_i),
    .data_i   (tx_data),
    .start_i  (tx_start),
    .busy_o   (tx_busy),
    .tx_o     (uart_tx_o)
  );

  ////////////////////////////////////////////////////////////
  // Command handling and memory
  ////////////////////////////////////////////////////////////

  dbg_cmd_engine u_dbg_cmd_engine (
    .jtag_tck   (jtag_tck),
    .rst_n_i    (rst_n_i),
    .rx_data_i  (rx_data),
    .rx_valid_i (rx_valid),
    .tx_data_o  (tx_data),
    .tx_start_o (tx_start),
    .tx_busy_i  (tx_busy),
    .wb_cyc_o   (wb_cyc),
    .wb_stb_o   (wb_stb),
    .wb_we_o    (wb_we),
    .wb_adr_o   (wb_adr),
    .wb_sel_o   (wb_sel),
    .wb_dat_o   (wb_wdata),
    .wb_dat_i   (wb_rdata),
    .wb_ack_i   (wb_ack)
  );

  wb_ram #(
    .MemWords (MemWords)
  ) u_wb_ram (
    .jtag_tck (jtag_tck),
    .rst_n_i  (rst_n_i),
    .wb_cyc_i (wb_cyc),
    .wb_stb_i (wb_stb),
    .wb_we_i  (wb_we),
    .wb_adr_i (wb_adr),
    .wb_sel_i (wb_sel),
    .wb_dat_i (wb_wdata),
    .wb_dat_o (wb_rdata),
    .wb_ack_o (wb_ack)
  );

endmodule

//--- sim/uart_dbg_chk.sv
module uart_dbg_chk (
  input logic                          jtag_tck,
  input logic                          rst_n_i,
  input logic                          tx_start_i,
  input logic                          tx_busy_i,
  input logic                          wb_cyc_i,
  input logic                          wb_stb_i,
  input logic                          wb_we_i,
  input logic [dbg_pkg::AddrWidth-1:0] wb_adr_i,
  input logic                          wb_ack_i
);

  timeunit 1ns;
  timeprecision 100ps;

  ////////////////////////////////////////////////////////////
  // Transmitter handshake
  ////////////////////////////////////////////////////////////

  // Single pulse into an idle transmitter which then reports busy
  a_tx_start_free: assert property (@(posedge jtag_tck) disable iff (!rst_n_i)
    tx_start_i |-> !tx_busy_i ##1 (tx_busy_i && !tx_start_i))
    else $error("tx_start not a single pulse into an idle transmitter");

  ////////////////////////////////////////////////////////////
  // Wishbone classic
  ////////////////////////////////////////////////////////////

  // Slave only answers inside a cycle the master holds
  a_stb_in_cyc: assert property (@(posedge jtag_tck) disable iff (!rst_n_i)
    (wb_stb_i || wb_ack_i) |-> wb_cyc_i)
    else $error("stb or ack high outside a bus cycle");

  // Request held until the slave answers
  a_req_stable: assert property (@(posedge jtag_tck) disable iff (!rst_n_i)
    (wb_stb_i && !wb_ack_i) |=> (wb_stb_i && $stable(wb_adr_i) && $stable(wb_we_i)))
    else $error("stb, adr or we changed before ack");

  // Master lets go in the cycle it sees ack
  a_ack_single: assert property (@(posedge jtag_tck) disable iff (!rst_n_i)
    wb_ack_i |=> (!wb_ack_i && !wb_stb_i))
    else $error("ack high for two cycles running or stb still high after ack");

endmodule

bind dbg_cmd_engine uart_dbg_chk u_uart_dbg_chk (
  .jtag_tck   (jtag_tck),
  .rst_n_i    (rst_n_i),
  .tx_start_i (tx_start_o),
  .tx_busy_i  (tx_busy_i),
  .wb_cyc_i   (wb_cyc_o),
  .wb_stb_i   (wb_stb_o),
  .wb_we_i    (wb_we_o),
  .wb_adr_i   (wb_adr_o),
  .wb_ack_i   (wb_ack_i)
);

//--- sim/tb_uart_dbg.sv
module tb_uart_dbg;

  timeunit 1ns;
  timeprecision 100ps;

  typedef logic [7:0] byte_q_t [$];

  localparam int unsigned BitClks     = 16;
  localparam int unsigned RespTimeout = 20000;
  localparam int unsigned QuietClks   = 400;

  logic        jtag_tck;
  logic        rst_n_i;
  logic        uart_rx_i;
  logic        uart_tx_o;

  logic [7:0]  model_mem [1024];
  byte_q_t     rx_q;
  byte_q_t     exp_q;
  byte_q_t     none;
  string       test_name;
  int unsigned test_err;
  int unsigned err_total;
  int unsigned tests_run;
  int unsigned tests_failed;
  logic        mon_busy;
  int unsigned mon_cnt;
  logic [7:0]  mon_shift;
  logic [7:0]  got;
  logic [7:0]  want;

  uart_dbg_top #(
    .ClksPerBit (16),
    .MemWords   (256)
  ) u_uart_dbg_top (
    .jtag_tck  (jtag_tck),
    .rst_n_i   (rst_n_i),
    .uart_rx_i (uart_rx_i),
    .uart_tx_o (uart_tx_o)
  );

  initial begin
    jtag_tck = 1'b0;
    forever #20 jtag_tck = ~jtag_tck;
  end

  ////////////////////////////////////////////////////////////
  // Reference model and bookkeeping
  ////////////////////////////////////////////////////////////

  // RAM holds 1024 bytes, so every byte address wraps modulo 1024
  function automatic byte_q_t expected_response(input logic [7:0] cmd, input logic [31:0] adr,
                                                input logic [31:0] len, input byte_q_t wdata);
    byte_q_t resp;
    if (cmd == dbg_pkg::DbgAck) begin
      resp.push_back(dbg_pkg::DbgAck);
    end else if (cmd == dbg_pkg::DbgCmdRead || cmd == dbg_pkg::DbgCmdWrite) begin
      resp.push_back(dbg_pkg::DbgAck);
      for (int unsigned i = 0; i < len; i++) begin
        if (cmd == dbg_pkg::DbgCmdRead) begin
          resp.push_back(model_mem[(adr + i) % 1024]);
        end else begin
          model_mem[(adr + i) % 1024] = wdata[i];
        end
      end
      resp.push_back(dbg_pkg::DbgEot);
    end
    return resp;
  endfunction

  function automatic byte_q_t random_bytes(input int unsigned n);
    byte_q_t     q;
    logic [31:0] r;
    for (int unsigned i = 0; i < n; i++) begin
      r = $urandom;
      q.push_back(r[7:0]);
    end
    return q;
  endfunction

  function automatic void count_error();
    test_err++;
    err_total++;
  endfunction

  function automatic void begin_test(input string name);
    test_name = name;
    test_err  = 0;
  endfunction

  function automatic void end_test();
    tests_run++;
    if (test_err == 0) begin
      $display("Test %s: ok", test_name);
    end else begin
      tests_failed++;
      $display("Test %s: %0d errors", test_name, test_err);
    end
  endfunction

  task automatic finish_run();
    $display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, err_total);
    if (err_total == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  endtask

  ////////////////////////////////////////////////////////////
  // Serial line monitor and compare
  ////////////////////////////////////////////////////////////

  // Start edge seen at count 0, so bit n is centred on count 16n+8
  always @(posedge jtag_tck) begin
    if (!rst_n_i) begin
      mon_busy = 1'b0;
    end else if (!mon_busy) begin
      if (uart_tx_o === 1'b0) begin
        mon_busy = 1'b1;
        mon_cnt  = 0;
      end
    end else begin
      mon_cnt++;
      if (mon_cnt % BitClks == 8 && mon_cnt > 8 && mon_cnt < 152) begin
        mon_shift = {uart_tx_o, mon_shift[7:1]};
      end
      if (mon_cnt == 152) begin
        mon_busy = 1'b0;
        assert (uart_tx_o === 1'b1) else begin
          $display("Stop bit low on the DUT serial output in test %s", test_name);
          count_error();
        end
        if (uart_tx_o === 1'b1) begin
          rx_q.push_back(mon_shift);
        end
      end
    end
  end

  always @(posedge jtag_tck) begin
    if (rx_q.size() > 0) begin
      got = rx_q.pop_front();
      assert (exp_q.size() > 0) else begin
        $display("Unexpected byte 0x%02h from the DUT in test %s", got, test_name);
        count_error();
      end
      if (exp_q.size() > 0) begin
        want = exp_q.pop_front();
        assert (got === want) else begin
          $display("[FAIL] %s: expected 0x%02h, actual 0x%02h", test_name, want, got);
          count_error();
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Host side
  ////////////////////////////////////////////////////////////

  task automatic send_byte(input logic [7:0] b);
    logic [9:0] frame;
    frame = {1'b1, b, 1'b0};
    @(posedge jtag_tck);
    for (int i = 0; i < 10; i++) begin
      #2 uart_rx_i = frame[i];
      repeat (BitClks) @(posedge jtag_tck);
    end
  endtask

  task automatic wait_for_responses(input int unsigned left);
    int unsigned cycles;
    cycles = 0;
    while (exp_q.size() > left && cycles < RespTimeout) begin
      @(posedge jtag_tck);
      cycles++;
    end
    if (exp_q.size() > left) begin
      $display("Timeout in test %s: %0d response bytes never arrived", test_name,
               exp_q.size() - left);
      count_error();
      finish_run();
    end
  endtask

  // Window long enough for a stray frame to show up
  task automatic watch_quiet();
    int unsigned cycles;
    cycles = 0;
    while (cycles < QuietClks) begin
      @(posedge jtag_tck);
      cycles++;
    end
  endtask

  task automatic run_cmd(input logic [7:0] cmd, input logic [31:0] adr,
                         input logic [31:0] len, input byte_q_t wdata);
    byte_q_t resp;
    resp = expected_response(cmd, adr, len, wdata);
    foreach (resp[i]) begin
      exp_q.push_back(resp[i]);
    end
    send_byte(cmd);
    if (cmd == dbg_pkg::DbgCmdRead || cmd == dbg_pkg::DbgCmdWrite) begin
      for (int k = 0; k < 4; k++) begin
        send_byte(adr[8*k +: 8]);
      end
      for (int k = 0; k < 4; k++) begin
        send_byte(len[8*k +: 8]);
      end
    end
    if (cmd == dbg_pkg::DbgCmdWrite) begin
      // Data only goes out once the ACK is back
      wait_for_responses(1);
      foreach (wdata[i]) begin
        send_byte(wdata[i]);
      end
    end
    wait_for_responses(0);
  endtask

  initial begin
    logic [31:0] adr;
    rst_n_i      = 1'b0;
    uart_rx_i    = 1'b1;
    test_name    = "reset";
    test_err     = 0;
    err_total    = 0;
    tests_run    = 0;
    tests_failed = 0;
    mon_busy     = 1'b0;
    mon_cnt      = 0;
    mon_shift    = '0;
    void'($urandom(32'hef29e43c));
    repeat (3) @(posedge jtag_tck);
    #2 rst_n_i = 1'b1;

    begin_test("ack_challenge");
    run_cmd(dbg_pkg::DbgAck, '0, '0, none);
    watch_quiet();
    end_test();

    begin_test("write_read");
    adr = $urandom;
    run_cmd(dbg_pkg::DbgCmdWrite, adr, 32'd16, random_bytes(16));
    run_cmd(dbg_pkg::DbgCmdRead, adr, 32'd16, none);
    end_test();

    // Second write starts on lane 3 inside the first one
    begin_test("byte_lanes");
    run_cmd(dbg_pkg::DbgCmdWrite, 32'h100, 32'd12, random_bytes(12));
    run_cmd(dbg_pkg::DbgCmdWrite, 32'h103, 32'd5, random_bytes(5));
    run_cmd(dbg_pkg::DbgCmdRead, 32'h100, 32'd12, none);
    end_test();

    begin_test("zero_length");
    run_cmd(dbg_pkg::DbgCmdRead, 32'h40, 32'd0, none);
    run_cmd(dbg_pkg::DbgCmdWrite, 32'h40, 32'd0, none);
    end_test();

    begin_test("unknown_and_wrap");
    run_cmd(8'h13, '0, '0, none);
    watch_quiet();
    run_cmd(dbg_pkg::DbgAck, '0, '0, none);
    run_cmd(dbg_pkg::DbgCmdWrite, 32'd1020, 32'd8, random_bytes(8));
    run_cmd(dbg_pkg::DbgCmdRead, 32'd0, 32'd4, none);
    watch_quiet();
    end_test();

    finish_run();
  end

endmodule

//--- tb.f
logic/dbg_pkg.sv
logic/uart_rx.sv
logic/uart_tx.sv
logic/dbg_cmd_engine.sv
logic/wb_ram.sv
logic/uart_dbg_top.sv
sim/uart_dbg_chk.sv
sim/tb_uart_dbg.sv

//--- Bender.yml
package:
  name: uart_dbg

sources:
  - logic/dbg_pkg.sv
  - logic/uart_rx.sv
  - logic/uart_tx.sv
  - logic/dbg_cmd_engine.sv
  - logic/wb_ram.sv
  - logic/uart_dbg_top.sv
  - target: test
    files:
      - sim/uart_dbg_chk.sv
      - sim/tb_uart_dbg.sv
